// File: hw/gamePkg.sv
// ==================================================
// game object types
// screen limits, fixed point format, pixel and draw
// request structs shared by the movers and combiner
// ==================================================
package gamePkg;

	// visible raster area
	localparam int SCREEN_WIDTH = 640;
	localparam int SCREEN_HEIGHT = 480;

	// positions keep 6 fraction bits, one pixel is 64 units
	localparam int FIXED_POINT_SHIFT = 6;

	typedef logic [10:0] coordT; // unsigned pixel coordinate
	typedef logic [7:0] colorT; // RGB332

	localparam colorT TRANSPARENT_COLOR = 8'hFF; // nothing drawn here

	// x and y of one pixel or one corner
	typedef struct packed {
		coordT x;
		coordT y;
	} pixelPosT;

	// what a mover hands on for the current pixel
	typedef struct packed {
		logic drawingRequest; // pixel inside the object
		pixelPosT topLeft; // integer top left corner
	} objectDrawT;

	// enemy heading, or decoded player step
	typedef enum logic [1:0] {
		MOVE_LEFT,
		MOVE_RIGHT,
		MOVE_STOP
	} moveDirT;

endpackage

// File: hw/enemyMover.sv
`timescale 1ns/1ps
// ==================================================
// enemy mover
// bounces a solid block left and right in 1/64 pixel
// steps and flags raster pixels inside its bracket
// ==================================================
module enemyMover #(
	parameter int INITIAL_X = 240,
	parameter int INITIAL_Y = 200,
	parameter int OBJECT_WIDTH = 30,
	parameter int OBJECT_HEIGHT = 30,
	parameter int X_SPEED = 120 // 1/64 pixel per frame
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input gamePkg::pixelPosT pixel,
	output gamePkg::objectDrawT enemyDraw
);
	import gamePkg::*;

	localparam int FIXED_MULT = 1 << FIXED_POINT_SHIFT;
	localparam int RIGHT_LIMIT = (SCREEN_WIDTH - OBJECT_WIDTH) * FIXED_MULT;

	int xFixed; // signed x, may dip below zero before turning
	moveDirT dir; // current heading
	moveDirT nextDir; // heading after the edge check
	pixelPosT topLeft;
	logic insideBracket;
	logic drawReq;

	// integer corner, division truncates toward zero
	always_comb begin
		topLeft.x = coordT'(xFixed / FIXED_MULT);
		topLeft.y = coordT'(INITIAL_Y); // no vertical motion
	end

	// turn around once past either edge
	always_comb begin
		nextDir = dir;
		if (xFixed < 0)
			nextDir = MOVE_RIGHT; // left edge crossed
		else if (xFixed > RIGHT_LIMIT)
			nextDir = MOVE_LEFT; // right edge crossed
	end

	// near edges inclusive, far edges excluded
	// blanking coordinates never draw
	always_comb begin
		insideBracket = (int'(pixel.x) >= int'(topLeft.x))
			&& (int'(pixel.x) < int'(topLeft.x) + OBJECT_WIDTH)
			&& (int'(pixel.y) >= int'(topLeft.y))
			&& (int'(pixel.y) < int'(topLeft.y) + OBJECT_HEIGHT)
			&& (int'(pixel.x) < SCREEN_WIDTH)
			&& (int'(pixel.y) < SCREEN_HEIGHT);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xFixed <= INITIAL_X * FIXED_MULT;
			dir <= MOVE_RIGHT;
			drawReq <= 1'b0;
		end else begin
			drawReq <= insideBracket; // answers the pixel of the previous cycle
			if (startOfFrame) begin
				dir <= nextDir;
				case (nextDir)
					MOVE_LEFT: xFixed <= xFixed - X_SPEED;
					MOVE_RIGHT: xFixed <= xFixed + X_SPEED;
					default: xFixed <= xFixed; // enemy never stops
				endcase
			end
		end
	end

	always_comb begin
		enemyDraw.drawingRequest = drawReq;
		enemyDraw.topLeft = topLeft;
	end

endmodule

// File: hw/playerMover.sv
`timescale 1ns/1ps
// ==================================================
// player mover
// steps a block left or right from two buttons, kept
// on screen, and flags pixels inside its bracket
// ==================================================
module playerMover #(
	parameter int INITIAL_X = 400,
	parameter int INITIAL_Y = 210,
	parameter int OBJECT_WIDTH = 32,
	parameter int OBJECT_HEIGHT = 16,
	parameter int STEP = 4 // whole pixels per frame
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic btnLeft,
	input logic btnRight,
	input gamePkg::pixelPosT pixel,
	output gamePkg::objectDrawT playerDraw
);
	import gamePkg::*;

	localparam int STEP_FIXED = STEP << FIXED_POINT_SHIFT;
	localparam int RIGHT_LIMIT = (SCREEN_WIDTH - OBJECT_WIDTH) << FIXED_POINT_SHIFT;

	int xFixed; // always within 0 .. RIGHT_LIMIT
	int xStep; // x after the raw step
	int xNext; // x after clamping
	moveDirT stepCmd;
	pixelPosT topLeft;
	logic insideBracket;
	logic drawReq;

	// one button moves, none or both hold still
	always_comb begin
		case ({btnLeft, btnRight})
			2'b10: stepCmd = MOVE_LEFT;
			2'b01: stepCmd = MOVE_RIGHT;
			default: stepCmd = MOVE_STOP;
		endcase
	end

	always_comb begin
		case (stepCmd)
			MOVE_LEFT: xStep = xFixed - STEP_FIXED;
			MOVE_RIGHT: xStep = xFixed + STEP_FIXED;
			default: xStep = xFixed;
		endcase
		if (xStep < 0)
			xNext = 0; // pinned at the left border
		else if (xStep > RIGHT_LIMIT)
			xNext = RIGHT_LIMIT; // pinned at the right border
		else
			xNext = xStep;
	end

	always_comb begin
		topLeft.x = coordT'(xFixed >>> FIXED_POINT_SHIFT); // never negative
		topLeft.y = coordT'(INITIAL_Y);
	end

	// same bracket rule as the enemy
	always_comb begin
		insideBracket = (int'(pixel.x) >= int'(topLeft.x))
			&& (int'(pixel.x) < int'(topLeft.x) + OBJECT_WIDTH)
			&& (int'(pixel.y) >= int'(topLeft.y))
			&& (int'(pixel.y) < int'(topLeft.y) + OBJECT_HEIGHT)
			&& (int'(pixel.x) < SCREEN_WIDTH) && (int'(pixel.y) < SCREEN_HEIGHT);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xFixed <= INITIAL_X << FIXED_POINT_SHIFT;
			drawReq <= 1'b0;
		end else begin
			drawReq <= insideBracket;
			if (startOfFrame)
				xFixed <= xNext; // one move per frame
		end
	end

	always_comb begin
		playerDraw.drawingRequest = drawReq;
		playerDraw.topLeft = topLeft;
	end

endmodule

// File: hw/drawCombiner.sv
`timescale 1ns/1ps
// ==================================================
// draw combiner
// merges the two draw requests into one pixel colour,
// player over enemy, and flags overlapping pixels
// ==================================================
module drawCombiner #(
	parameter gamePkg::colorT PLAYER_COLOR = 8'h1C,
	parameter gamePkg::colorT ENEMY_COLOR = 8'h5B
) (
	input logic clk,
	input logic resetN,
	input gamePkg::objectDrawT enemyDraw,
	input gamePkg::objectDrawT playerDraw,
	output gamePkg::colorT pixelColor,
	output logic collision
);
	import gamePkg::*;

	logic enemyReq;
	logic playerReq;
	colorT colorNext;

	// only the request bits matter here
	assign enemyReq = enemyDraw.drawingRequest;
	assign playerReq = playerDraw.drawingRequest;

	// priority mux, player on top
	always_comb begin
		if (playerReq)
			colorNext = PLAYER_COLOR;
		else if (enemyReq)
			colorNext = ENEMY_COLOR;
		else
			colorNext = TRANSPARENT_COLOR; // background shows through
	end

	// second pipeline stage
	// colour and collision line up with each other
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pixelColor <= TRANSPARENT_COLOR;
			collision <= 1'b0;
		end else begin
			pixelColor <= colorNext;
			collision <= playerReq && enemyReq; // both objects on this pixel
		end
	end

endmodule

// File: hw/gameObjectsTop.sv
`timescale 1ns/1ps
// ==================================================
// game objects top
// enemy and player movers feeding the draw combiner,
// pixel in to colour out in two cycles
// ==================================================
module gameObjectsTop #(
	parameter int ENEMY_INITIAL_X = 240,
	parameter int ENEMY_INITIAL_Y = 200,
	parameter int ENEMY_WIDTH = 30,
	parameter int ENEMY_HEIGHT = 30,
	parameter int ENEMY_X_SPEED = 120, // 1/64 pixel per frame
	parameter int PLAYER_INITIAL_X = 400,
	parameter int PLAYER_INITIAL_Y = 210,
	parameter int PLAYER_WIDTH = 32,
	parameter int PLAYER_HEIGHT = 16,
	parameter int PLAYER_STEP = 4,
	parameter gamePkg::colorT PLAYER_COLOR = 8'h1C,
	parameter gamePkg::colorT ENEMY_COLOR = 8'h5B
) (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one cycle per frame
	input gamePkg::pixelPosT pixel,
	input logic btnLeft,
	input logic btnRight,
	output gamePkg::colorT pixelColor,
	output logic collision,
	output gamePkg::pixelPosT enemyPos,
	output gamePkg::pixelPosT playerPos
);
	import gamePkg::*;

	objectDrawT enemyDraw;
	objectDrawT playerDraw;

	enemyMover #(
		.INITIAL_X(ENEMY_INITIAL_X),
		.INITIAL_Y(ENEMY_INITIAL_Y),
		.OBJECT_WIDTH(ENEMY_WIDTH),
		.OBJECT_HEIGHT(ENEMY_HEIGHT),
		.X_SPEED(ENEMY_X_SPEED)
	) enemy (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.pixel(pixel),
		.enemyDraw(enemyDraw)
	);

	playerMover #(
		.INITIAL_X(PLAYER_INITIAL_X),
		.INITIAL_Y(PLAYER_INITIAL_Y),
		.OBJECT_WIDTH(PLAYER_WIDTH),
		.OBJECT_HEIGHT(PLAYER_HEIGHT),
		.STEP(PLAYER_STEP)
	) player (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.btnLeft(btnLeft),
		.btnRight(btnRight),
		.pixel(pixel),
		.playerDraw(playerDraw)
	);

	drawCombiner #(
		.PLAYER_COLOR(PLAYER_COLOR),
		.ENEMY_COLOR(ENEMY_COLOR)
	) combiner (
		.clk(clk),
		.resetN(resetN),
		.enemyDraw(enemyDraw),
		.playerDraw(playerDraw),
		.pixelColor(pixelColor),
		.collision(collision)
	);

	// corners straight from the movers
	assign enemyPos = enemyDraw.topLeft;
	assign playerPos = playerDraw.topLeft;

endmodule

// File: verification/gameObjectsAssert.sv
`timescale 1ns/1ps
// ==================================================
// draw combiner assertions
// colour priority, transparent background and a
// quiet collision flag during reset
// ==================================================
module gameObjectsAssert #(
	parameter gamePkg::colorT PLAYER_COLOR = 8'h1C
) (
	input logic clk,
	input logic resetN,
	input gamePkg::objectDrawT enemyDraw,
	input gamePkg::objectDrawT playerDraw,
	input gamePkg::colorT pixelColor,
	input logic collision
);
	import gamePkg::*;

	// overlap always shows the player on top
	collisionShowsPlayer: assert property (@(posedge clk) disable iff (!resetN)
		collision |-> pixelColor == PLAYER_COLOR)
		else $error("collision flagged with a colour other than the player colour");

	// no request, background one cycle later
	idleIsTransparent: assert property (@(posedge clk) disable iff (!resetN)
		!enemyDraw.drawingRequest && !playerDraw.drawingRequest
		|=> pixelColor == TRANSPARENT_COLOR)
		else $error("pixel coloured although neither object requested it");

	collisionQuietInReset: assert property (@(posedge clk) !resetN |-> !collision)
		else $error("collision high while in reset");

endmodule

// File: verification/gameObjectsChecker.sv
`timescale 1ns/1ps
// ==================================================
// game objects checker
// compares positions after a frame and the colour
// two cycles after each probe, counts the errors
// ==================================================
module gameObjectsChecker (
	input logic clk,
	input logic startOfFrame,
	input logic resetCheck, // compare outputs as they stand
	input logic frameCheck, // positions after this frame
	input logic probeCheck, // colour of this pixel
	input gamePkg::pixelPosT expEnemy,
	input gamePkg::pixelPosT expPlayer,
	input gamePkg::colorT expColor,
	input logic expCollision,
	input gamePkg::colorT pixelColor,
	input logic collision,
	input gamePkg::pixelPosT enemyPos,
	input gamePkg::pixelPosT playerPos,
	output int errorCount,
	output int checkCount,
	output logic pending // a compare is still due
);
	import gamePkg::*;

	int errors = 0;
	int checks = 0;
	logic frameSeen = 1'b0; // frame pulse taken, compare next edge
	logic probeD1 = 1'b0;
	logic probeD2 = 1'b0;
	pixelPosT enemyWant, playerWant;
	colorT colorD1, colorD2; // expected colour walks with the pixel
	logic collD1, collD2;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error %s expected %h got %h at %0t", name, want, got, $time);
		end
	endtask

	always @(posedge clk) begin
		if (resetCheck) begin
			compare("enemyPos", 32'(enemyPos), 32'(expEnemy));
			compare("playerPos", 32'(playerPos), 32'(expPlayer));
			compare("pixelColor", 32'(pixelColor), 32'(expColor));
			compare("collision", 32'(collision), 32'(expCollision));
		end
		if (frameSeen) begin
			compare("enemyPos", 32'(enemyPos), 32'(enemyWant));
			compare("playerPos", 32'(playerPos), 32'(playerWant));
		end
		if (probeD2) begin // mover stage plus combiner stage
			compare("pixelColor", 32'(pixelColor), 32'(colorD2));
			compare("collision", 32'(collision), 32'(collD2));
		end
		frameSeen <= startOfFrame && frameCheck;
		enemyWant <= expEnemy;
		playerWant <= expPlayer;
		probeD1 <= probeCheck;
		colorD1 <= expColor;
		collD1 <= expCollision;
		probeD2 <= probeD1;
		colorD2 <= colorD1;
		collD2 <= collD1;
	end

	assign errorCount = errors;
	assign checkCount = checks;
	assign pending = frameSeen | probeD1 | probeD2;

endmodule

// File: verification/gameObjectsTb.sv
`timescale 1ns/1ps
// ==================================================
// game objects testbench
// replays frame commands and pixel probes from the
// data file while the checker compares the outputs
// ==================================================
module gameObjectsTb;
	import gamePkg::*;

	localparam int IDLE_TIMEOUT = 20; // cycles for the checker to drain

	logic clk = 1'b0;
	logic resetN;
	logic startOfFrame;
	logic btnLeft, btnRight;
	pixelPosT pixel;
	colorT pixelColor;
	logic collision;
	pixelPosT enemyPos, playerPos;
	logic resetCheck, frameCheck, probeCheck; // strobes to the checker
	pixelPosT expEnemy, expPlayer;
	colorT expColor;
	logic expCollision;
	int errorCount, checkCount;
	logic pending;
	logic timedOut = 1'b0;
	logic fileMissing = 1'b0;

	always #20 clk = ~clk; // 40 ns period

	gameObjectsTop DUT (.*);
	gameObjectsChecker scoreboard (.*);
	bind drawCombiner gameObjectsAssert #(.PLAYER_COLOR(PLAYER_COLOR)) combinerProps (.*);

	// positions are compared after the last frame pulse only
	task automatic runFrames(input int frames, input logic left, input logic right,
		input pixelPosT enemyWant, input pixelPosT playerWant);
		for (int i = 0; i < frames; i++) begin
			@(posedge clk);
			probeCheck <= 1'b0;
			btnLeft <= left;
			btnRight <= right;
			startOfFrame <= 1'b1;
			frameCheck <= (i == frames - 1);
			expEnemy <= enemyWant;
			expPlayer <= playerWant;
			@(posedge clk);
			startOfFrame <= 1'b0;
			frameCheck <= 1'b0;
			repeat (3) @(posedge clk); // pixel held, outputs ignored
		end
	endtask

	initial begin
		int fd;
		int cycles;
		int v [7];
		string line;
		byte kind;
		resetN <= 1'b0;
		startOfFrame <= 1'b0;
		btnLeft <= 1'b0;
		btnRight <= 1'b0;
		pixel <= '{x: 11'd700, y: 11'd500}; // blanking area where nothing draws
		resetCheck <= 1'b0;
		frameCheck <= 1'b0;
		probeCheck <= 1'b0;
		expEnemy <= '0;
		expPlayer <= '0;
		expColor <= '0;
		expCollision <= 1'b0;
		repeat (16) @(posedge clk);
		resetN <= 1'b1;
		fd = $fopen("verification/gameObjects_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			fileMissing = 1'b1;
		end else begin
			while ($fgets(line, fd) != 0) begin
				kind = 8'd0;
				void'($sscanf(line, "%c %h %h %h %h %h %h %h", kind,
					v[0], v[1], v[2], v[3], v[4], v[5], v[6]));
				case (kind)
					"R": begin
						@(posedge clk);
						resetCheck <= 1'b1;
						expEnemy <= {coordT'(v[0]), coordT'(v[1])};
						expPlayer <= {coordT'(v[2]), coordT'(v[3])};
						expColor <= colorT'(v[4]);
						expCollision <= v[5][0];
						@(posedge clk);
						resetCheck <= 1'b0;
					end
					"F": runFrames(v[0], v[1][0], v[2][0], {coordT'(v[3]), coordT'(v[4])},
						{coordT'(v[5]), coordT'(v[6])});
					"P": begin // one pixel per cycle
						@(posedge clk);
						pixel <= {coordT'(v[0]), coordT'(v[1])};
						probeCheck <= 1'b1;
						expColor <= colorT'(v[2]);
						expCollision <= v[3][0];
					end
					default: ; // comment or blank line
				endcase
			end
			$fclose(fd);
		end
		@(posedge clk);
		probeCheck <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (pending && cycles < IDLE_TIMEOUT);
		if (pending) begin
			$display("timeout while the checker still had compares pending");
			timedOut = 1'b1;
		end
		$display("checks %0d errors %0d timeouts %0d", checkCount, errorCount, timedOut);
		if (errorCount == 0 && !timedOut && !fileMissing && checkCount > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verification/gameObjects_testdata.txt
# R enemyX enemyY playerX playerY color collision | P pixelX pixelY color collision
# F frames btnLeft btnRight enemyX enemyY playerX playerY, positions after the last frame, hex
R 0F0 0C8 190 0D2 FF 0
F 1 0 0 0F1 0C8 190 0D2
F 1 0 1 0F3 0C8 194 0D2
F 1 1 1 0F5 0C8 194 0D2
P 0F5 0C8 5B 0
P 112 0E5 5B 0
P 113 0C8 FF 0
P 0F5 0E6 FF 0
P 194 0D2 1C 0
P 1B3 0E1 1C 0
P 1B4 0D2 FF 0
P 193 0D2 FF 0
F 1E 1 0 12D 0C8 11C 0D2
P 12D 0D2 1C 1
P 13B 0E1 1C 1
P 13C 0D2 5B 0
P 12C 0D2 1C 0
F 50 1 0 1C3 0C8 000 0D2
P 000 0D2 1C 0
P 020 0D2 FF 0
F 55 0 1 263 0C8 154 0D2
F 1 0 1 261 0C8 158 0D2
F 4B 0 1 1D4 0C8 260 0D2
F 1 0 0 1D2 0C8 260 0D2
P 27F 0E1 1C 0
P 25F 0D2 FF 0

// File: src.f
hw/gamePkg.sv
hw/enemyMover.sv
hw/playerMover.sv
hw/drawCombiner.sv
hw/gameObjectsTop.sv
verification/gameObjectsAssert.sv
verification/gameObjectsChecker.sv
verification/gameObjectsTb.sv

// File: run.sh
#!/bin/sh
# build the game objects testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module gameObjectsTb -o gameObjectsSim
./obj_dir/gameObjectsSim | tee sim.log
grep -q "Simulation completed successfully" sim.log
